/* Bender.yml */
package:
  name: banked_ram

sources:
  # Shared definitions first, then leaf modules, then the top level
  - files:
      - hw/banked_ram_pkg.sv
      - hw/ram_sdp_bank.sv
      - hw/axil_bank_dispatch.sv
      - hw/axil_read_collect.sv
      - hw/banked_ram_axil.sv

  # Testbench, simulation only
  - target: simulation
    files:
      - sim/tb_banked_ram.sv

/* banked_ram.f */
hw/banked_ram_pkg.sv
hw/ram_sdp_bank.sv
hw/axil_bank_dispatch.sv
hw/axil_read_collect.sv
hw/banked_ram_axil.sv
sim/tb_banked_ram.sv

/* hw/axil_bank_dispatch.sv */
// AXI4-Lite request side and bank decode
`timescale 1ns/1ps

module axil_bank_dispatch (
    input  logic                       rd_clk,
    input  logic                       rd_srst,

    // AW and W
    input  logic                       awvalid,
    input  banked_ram_pkg::axil_addr_t awaddr,
    output logic                       awready,
    input  logic                       wvalid,
    input  banked_ram_pkg::word_t      wdata,
    input  banked_ram_pkg::strb_t      wstrb,
    output logic                       wready,

    // B
    output logic                       bvalid,
    output banked_ram_pkg::axil_resp_t bresp,
    input  logic                       bready,

    // AR
    input  logic                       arvalid,
    input  banked_ram_pkg::axil_addr_t araddr,
    output logic                       arready,

    // Bank side
    output banked_ram_pkg::bank_wr_t   wr_req [banked_ram_pkg::NUM_BANKS],
    output banked_ram_pkg::bank_rd_t   rd_req [banked_ram_pkg::NUM_BANKS],

    // Collector side
    output logic                       rd_issue,
    output banked_ram_pkg::bank_sel_t  rd_issue_bank,
    input  logic                       rd_credit
);
    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    banked_ram_pkg::bank_sel_t  aw_bank;
    banked_ram_pkg::bank_addr_t aw_word;
    banked_ram_pkg::bank_sel_t  ar_bank;
    banked_ram_pkg::bank_addr_t ar_word;

    // Bits 1:0 dropped, word index next, bank on top
    assign aw_word = awaddr[banked_ram_pkg::WORD_LSB +: banked_ram_pkg::BANK_ADDR_WID];
    assign aw_bank = awaddr[banked_ram_pkg::AXI_ADDR_WID-1 -: banked_ram_pkg::BANK_SEL_WID];
    assign ar_word = araddr[banked_ram_pkg::WORD_LSB +: banked_ram_pkg::BANK_ADDR_WID];
    assign ar_bank = araddr[banked_ram_pkg::AXI_ADDR_WID-1 -: banked_ram_pkg::BANK_SEL_WID];

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    banked_ram_pkg::wr_state_t  wr_state;
    logic                       aw_fire;
    logic                       strb_full;
    logic [banked_ram_pkg::NUM_BANKS-1:0] wr_hit_q;
    banked_ram_pkg::bank_addr_t wr_addr_q;
    banked_ram_pkg::word_t      wr_data_q;

    // AW and W accepted together, one write at a time
    assign aw_fire   = (wr_state == banked_ram_pkg::WR_IDLE) && awvalid && wvalid;
    assign awready   = aw_fire;
    assign wready    = aw_fire;
    // Only whole-word writes reach the array
    assign strb_full = (wstrb == '1);
    assign bvalid    = (wr_state == banked_ram_pkg::WR_RESP);

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            wr_state <= banked_ram_pkg::WR_IDLE;
            wr_hit_q <= '0;
        end else begin
            // Bank req is a single-cycle pulse
            wr_hit_q <= '0;
            unique case (wr_state)
                banked_ram_pkg::WR_IDLE: begin
                    if (aw_fire) begin
                        wr_state <= banked_ram_pkg::WR_RESP;
                        if (strb_full) begin
                            wr_hit_q[aw_bank] <= 1'b1;
                        end
                    end
                end
                banked_ram_pkg::WR_RESP: begin
                    if (bready) begin
                        wr_state <= banked_ram_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= banked_ram_pkg::WR_IDLE;
            endcase
        end
    end

    // Write payload and response code
    always_ff @(posedge rd_clk) begin
        if (aw_fire) begin
            wr_addr_q <= aw_word;
            wr_data_q <= wdata;
            bresp     <= strb_full ? banked_ram_pkg::RESP_OKAY : banked_ram_pkg::RESP_SLVERR;
        end
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    logic                       ar_fire;
    logic [banked_ram_pkg::NUM_BANKS-1:0] rd_en_q;
    banked_ram_pkg::bank_addr_t rd_addr_q;

    // Collector owns flow control
    assign arready = rd_credit;
    assign ar_fire = arvalid && rd_credit;

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_en_q  <= '0;
            rd_issue <= 1'b0;
        end else begin
            rd_en_q <= '0;
            if (ar_fire) begin
                rd_en_q[ar_bank] <= 1'b1;
            end
            rd_issue <= ar_fire;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (ar_fire) begin
            rd_addr_q     <= ar_word;
            rd_issue_bank <= ar_bank;
        end
    end

    // Shared payload, per-bank strobes
    generate
        for (genvar b = 0; b < banked_ram_pkg::NUM_BANKS; b++) begin : g_req
            assign wr_req[b] = '{req: wr_hit_q[b], addr: wr_addr_q, data: wr_data_q};
            assign rd_req[b] = '{en: rd_en_q[b], addr: rd_addr_q};
        end
    endgenerate

    // B beat held until taken
    a_b_hold : assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("B dropped before bready");

    a_rd_onehot : assert property (
        @(posedge rd_clk) disable iff (rd_srst) $onehot0(rd_en_q)
    ) else $error("More than one bank read enable");

endmodule : axil_bank_dispatch

/* hw/axil_read_collect.sv */
// Read return path with response buffer
`timescale 1ns/1ps

module axil_read_collect (
    input  logic                       rd_clk,
    input  logic                       rd_srst,

    // From dispatcher
    input  logic                       rd_issue,
    input  banked_ram_pkg::bank_sel_t  rd_issue_bank,
    output logic                       rd_credit,

    // From banks
    input  banked_ram_pkg::word_t      bank_rd_data [banked_ram_pkg::NUM_BANKS],

    // R
    output logic                       rvalid,
    output banked_ram_pkg::word_t      rdata,
    output banked_ram_pkg::axil_resp_t rresp,
    input  logic                       rready
);
    localparam int LAT = banked_ram_pkg::BANK_RD_LATENCY;

    // ------------------------------------------------------------
    // Bank number delay line
    // ------------------------------------------------------------
    // Tracks the bank latency; the FIFO write is the last stage
    logic [LAT-1:0]            dly_vld;
    banked_ram_pkg::bank_sel_t dly_bank [LAT];
    logic                      push;
    banked_ram_pkg::axil_r_t   push_beat;

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            dly_vld <= '0;
        end else begin
            dly_vld[0] <= rd_issue;
            for (int i = 1; i < LAT; i++) begin
                dly_vld[i] <= dly_vld[i-1];
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        dly_bank[0] <= rd_issue_bank;
        for (int i = 1; i < LAT; i++) begin
            dly_bank[i] <= dly_bank[i-1];
        end
    end

    // Bank data valid this cycle
    assign push      = dly_vld[LAT-1];
    assign push_beat = '{
        data: bank_rd_data[dly_bank[LAT-1]],
        resp: banked_ram_pkg::RESP_OKAY
    };

    // ------------------------------------------------------------
    // Response FIFO
    // ------------------------------------------------------------
    banked_ram_pkg::axil_r_t fifo_mem [banked_ram_pkg::R_FIFO_DEPTH];
    // Extra MSB tells full from empty
    logic [banked_ram_pkg::R_PTR_WID:0] wr_ptr;
    logic [banked_ram_pkg::R_PTR_WID:0] rd_ptr;
    logic                               fifo_empty;
    logic                               fifo_full;
    logic                               pop;
    banked_ram_pkg::axil_r_t            head;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[banked_ram_pkg::R_PTR_WID] != rd_ptr[banked_ram_pkg::R_PTR_WID])
                     && (wr_ptr[banked_ram_pkg::R_PTR_WID-1:0]
                         == rd_ptr[banked_ram_pkg::R_PTR_WID-1:0]);
    assign pop        = rvalid && rready;

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (push) begin
            fifo_mem[wr_ptr[banked_ram_pkg::R_PTR_WID-1:0]] <= push_beat;
        end
    end

    // R driven from head entry
    assign head   = fifo_mem[rd_ptr[banked_ram_pkg::R_PTR_WID-1:0]];
    assign rvalid = !fifo_empty;
    assign rdata  = head.data;
    assign rresp  = head.resp;

    // ------------------------------------------------------------
    // Credit
    // ------------------------------------------------------------
    // In flight plus buffered reads
    logic [banked_ram_pkg::R_CNT_WID-1:0] rd_cnt;
    logic [banked_ram_pkg::R_CNT_WID-1:0] rd_cnt_eff;

    // Issue in its first cycle is not yet counted
    assign rd_cnt_eff = rd_cnt + banked_ram_pkg::R_CNT_WID'(rd_issue);
    assign rd_credit  = (rd_cnt_eff < banked_ram_pkg::R_CNT_WID'(banked_ram_pkg::R_FIFO_DEPTH));

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_cnt <= '0;
        end else begin
            rd_cnt <= rd_cnt_eff - banked_ram_pkg::R_CNT_WID'(pop);
        end
    end

    // Credit must keep the buffer from filling past depth
    a_no_overflow : assert property (
        @(posedge rd_clk) disable iff (rd_srst) push |-> !fifo_full
    ) else $error("Response FIFO overflow");

    a_r_hold : assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("R beat changed before rready");

endmodule : axil_read_collect

/* hw/banked_ram_axil.sv */
// Banked RAM with AXI4-Lite slave
`timescale 1ns/1ps

module banked_ram_axil (
    input  logic                       rd_clk,
    input  logic                       rd_srst,

    // Write address and data
    input  logic                       awvalid,
    output logic                       awready,
    input  banked_ram_pkg::axil_addr_t awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  banked_ram_pkg::word_t      wdata,
    input  banked_ram_pkg::strb_t      wstrb,

    // Write response
    output logic                       bvalid,
    input  logic                       bready,
    output banked_ram_pkg::axil_resp_t bresp,

    // Read address
    input  logic                       arvalid,
    output logic                       arready,
    input  banked_ram_pkg::axil_addr_t araddr,

    // Read data
    output logic                       rvalid,
    input  logic                       rready,
    output banked_ram_pkg::word_t      rdata,
    output banked_ram_pkg::axil_resp_t rresp
);
    banked_ram_pkg::bank_wr_t  wr_req       [banked_ram_pkg::NUM_BANKS];
    banked_ram_pkg::bank_rd_t  rd_req       [banked_ram_pkg::NUM_BANKS];
    banked_ram_pkg::word_t     bank_rd_data [banked_ram_pkg::NUM_BANKS];
    logic                      rd_issue;
    banked_ram_pkg::bank_sel_t rd_issue_bank;
    logic                      rd_credit;

    // Request side
    axil_bank_dispatch u_dispatch (
        .rd_clk        (rd_clk),
        .rd_srst       (rd_srst),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wready        (wready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .bready        (bready),
        .arvalid       (arvalid),
        .araddr        (araddr),
        .arready       (arready),
        .wr_req        (wr_req),
        .rd_req        (rd_req),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank),
        .rd_credit     (rd_credit)
    );

    // Memory banks
    generate
        for (genvar b = 0; b < banked_ram_pkg::NUM_BANKS; b++) begin : g_bank
            ram_sdp_bank #(
                .ADDR_WID (banked_ram_pkg::BANK_ADDR_WID),
                .DATA_WID (banked_ram_pkg::DATA_WID),
                .OPT_MODE (banked_ram_pkg::BANK_OPT_MODE)
            ) u_bank (
                .rd_clk  (rd_clk),
                .rd_srst (rd_srst),
                .wr      (wr_req[b]),
                .rd      (rd_req[b]),
                .rd_data (bank_rd_data[b])
            );
        end
    endgenerate

    // Return side
    axil_read_collect u_collect (
        .rd_clk        (rd_clk),
        .rd_srst       (rd_srst),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank),
        .rd_credit     (rd_credit),
        .bank_rd_data  (bank_rd_data),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rready        (rready)
    );

endmodule : banked_ram_axil

/* hw/banked_ram_pkg.sv */
// Banked RAM shared definitions
package banked_ram_pkg;

    // ------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------
    localparam int NUM_BANKS     = 4;
    localparam int BANK_SEL_WID  = $clog2(NUM_BANKS);
    localparam int BANK_ADDR_WID = 8;
    localparam int DATA_WID      = 32;
    localparam int STRB_WID      = DATA_WID / 8;
    // Byte offset bits below the word index
    localparam int WORD_LSB      = 2;
    localparam int AXI_ADDR_WID  = WORD_LSB + BANK_ADDR_WID + BANK_SEL_WID;

    // Plain vector types
    typedef logic [DATA_WID-1:0]      word_t;
    typedef logic [BANK_ADDR_WID-1:0] bank_addr_t;
    typedef logic [BANK_SEL_WID-1:0]  bank_sel_t;
    typedef logic [AXI_ADDR_WID-1:0]  axil_addr_t;
    typedef logic [1:0]               axil_resp_t;
    typedef logic [STRB_WID-1:0]      strb_t;

    // AXI response codes
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // ------------------------------------------------------------
    // Bank mode and read pipeline
    // ------------------------------------------------------------
    // Timing mode adds the block-RAM output register
    typedef enum logic {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    localparam opt_mode_t BANK_OPT_MODE = OPT_MODE_TIMING;
    localparam int BANK_RD_LATENCY = (BANK_OPT_MODE == OPT_MODE_TIMING) ? 2 : 1;

    // Response buffer, power of two
    localparam int R_FIFO_DEPTH = 4;
    localparam int R_PTR_WID    = $clog2(R_FIFO_DEPTH);
    // Counts 0..R_FIFO_DEPTH plus one not yet counted issue
    localparam int R_CNT_WID    = $clog2(R_FIFO_DEPTH + 2);

    // Write response FSM
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    // ------------------------------------------------------------
    // Bank request and response records
    // ------------------------------------------------------------
    // Write request, same payload to every bank
    typedef struct packed {
        logic       req;
        bank_addr_t addr;
        word_t      data;
    } bank_wr_t;

    // Read request, one bank enabled at a time
    typedef struct packed {
        logic       en;
        bank_addr_t addr;
    } bank_rd_t;

    // One buffered R beat
    typedef struct packed {
        word_t      data;
        axil_resp_t resp;
    } axil_r_t;

endpackage : banked_ram_pkg

/* hw/ram_sdp_bank.sv */
// Simple dual-port block-RAM bank
`timescale 1ns/1ps

module ram_sdp_bank #(
    parameter int ADDR_WID = banked_ram_pkg::BANK_ADDR_WID,
    parameter int DATA_WID = banked_ram_pkg::DATA_WID,
    parameter banked_ram_pkg::opt_mode_t OPT_MODE = banked_ram_pkg::BANK_OPT_MODE
) (
    input  logic                     rd_clk,
    input  logic                     rd_srst,
    input  banked_ram_pkg::bank_wr_t wr,
    input  banked_ram_pkg::bank_rd_t rd,
    output banked_ram_pkg::word_t    rd_data
);
    localparam int DEPTH      = 2 ** ADDR_WID;
    localparam bit OUT_REG_EN = (OPT_MODE == banked_ram_pkg::OPT_MODE_TIMING);

    typedef logic [DATA_WID-1:0] data_t;
    typedef logic [ADDR_WID-1:0] addr_t;

    // Storage, no reset
    (* ram_style = "block" *) data_t mem [DEPTH];

    addr_t wr_addr;
    addr_t rd_addr;
    data_t wr_data;
    // Array read register
    data_t mem_q;

    // Resize request fields to this bank's geometry
    assign wr_addr = addr_t'(wr.addr);
    assign rd_addr = addr_t'(rd.addr);
    assign wr_data = data_t'(wr.data);

    // Write lands one edge after req
    always_ff @(posedge rd_clk) begin
        if (wr.req) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // First read stage
    always_ff @(posedge rd_clk) begin
        if (rd.en) begin
            mem_q <= mem[rd_addr];
        end
    end

    generate
        if (OUT_REG_EN) begin : g_out_reg
            // Output register, second read stage
            always_ff @(posedge rd_clk) begin
                if (rd_srst) begin
                    rd_data <= '0;
                end else begin
                    rd_data <= banked_ram_pkg::word_t'(mem_q);
                end
            end
        end else begin : g_no_out_reg
            assign rd_data = banked_ram_pkg::word_t'(mem_q);
        end
    endgenerate

    // Enable must be driven once out of reset
    a_rd_en_known : assert property (
        @(posedge rd_clk) disable iff (rd_srst) !$isunknown(rd.en)
    ) else $error("rd.en unknown");

endmodule : ram_sdp_bank

/* sim/tb_banked_ram.sv */
// Banked RAM AXI4-Lite testbench
`timescale 1ns/1ps

module tb_banked_ram;

    localparam int SEED         = 73;
    localparam int RESET_CYCLES = 8;
    // Idle cycles allowed before a wait gives up
    localparam int TIMEOUT      = 200;
    localparam int STALL_CYCLES = 20;
    localparam int MIX_OPS      = 300;
    localparam int NUM_WORDS    = banked_ram_pkg::NUM_BANKS << banked_ram_pkg::BANK_ADDR_WID;

    // DUT inputs
    logic                       rd_clk;
    logic                       rd_srst;
    logic                       awvalid;
    banked_ram_pkg::axil_addr_t awaddr;
    logic                       wvalid;
    banked_ram_pkg::word_t      wdata;
    banked_ram_pkg::strb_t      wstrb;
    logic                       bready;
    logic                       arvalid;
    banked_ram_pkg::axil_addr_t araddr;
    logic                       rready;

    // DUT outputs
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    banked_ram_pkg::axil_resp_t bresp;
    logic                       arready;
    logic                       rvalid;
    banked_ram_pkg::word_t      rdata;
    banked_ram_pkg::axil_resp_t rresp;

    // Reference memory indexed by {bank, word}
    banked_ram_pkg::word_t model_mem [NUM_WORDS];
    bit                    written   [NUM_WORDS];
    int                    written_q [$];
    // Word indices for the next read burst
    int                    plan_q    [$];

    banked_ram_axil UUT (
        .rd_clk  (rd_clk),
        .rd_srst (rd_srst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    // 20 ns clock
    always #10 rd_clk = ~rd_clk;

    // ------------------------------------------------------------
    // Error handling and compares
    // ------------------------------------------------------------
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_low(input logic got, input string name);
        if (got !== 1'b0) begin
            stop_run($sformatf("Error: %s got 0x%h expected 0x0", name, got));
        end
    endtask

    task automatic check_bresp(input banked_ram_pkg::axil_resp_t got,
                               input banked_ram_pkg::axil_resp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: bresp got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_rdata(input banked_ram_pkg::axil_r_t got,
                               input banked_ram_pkg::axil_r_t exp);
        if (got.data !== exp.data) begin
            stop_run($sformatf("Error: rdata got 0x%h expected 0x%h", got.data, exp.data));
        end
        if (got.resp !== exp.resp) begin
            stop_run($sformatf("Error: rresp got 0x%h expected 0x%h", got.resp, exp.resp));
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // Byte address from word index with random ignored low bits
    function automatic banked_ram_pkg::axil_addr_t make_addr(input int idx);
        return banked_ram_pkg::axil_addr_t'((idx << banked_ram_pkg::WORD_LSB)
                                            | $urandom_range(3));
    endfunction

    // One AW/W pair and its B beat under random bready
    task automatic do_write(input int idx, input banked_ram_pkg::word_t data,
                            input banked_ram_pkg::strb_t strb);
        int                         wait_cnt;
        bit                         b_done;
        banked_ram_pkg::axil_resp_t exp_resp;
        // Only a full strobe is accepted
        exp_resp = (strb == 4'hF) ? 2'b00 : 2'b10;
        awvalid  <= 1'b1;
        awaddr   <= make_addr(idx);
        wvalid   <= 1'b1;
        wdata    <= data;
        wstrb    <= strb;
        wait_cnt = 0;
        do begin
            @(posedge rd_clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run("Timeout waiting for the write address and data to be accepted");
            end
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'($urandom_range(1));
        wait_cnt = 0;
        b_done   = 1'b0;
        while (!b_done) begin
            @(posedge rd_clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run("Timeout waiting for the write response");
            end
            if (bvalid && bready) begin
                check_bresp(bresp, exp_resp);
                b_done = 1'b1;
            end else begin
                bready <= 1'($urandom_range(1));
            end
        end
        bready <= 1'b0;
        // Model takes full-strobe writes only
        if (strb == 4'hF) begin
            if (!written[idx]) begin
                written[idx] = 1'b1;
                written_q.push_back(idx);
            end
            model_mem[idx] = data;
        end
    endtask

    task automatic fill_random_reads(input int n);
        plan_q.delete();
        for (int i = 0; i < n; i++) begin
            plan_q.push_back(written_q[$urandom_range(written_q.size() - 1)]);
        end
    endtask

    // Read burst over plan_q
    // Mode 0 keeps rready high
    // Mode 1 randomizes rready and AR gaps
    // Mode 2 stalls R long then drains
    task automatic run_reads(input int mode);
        banked_ram_pkg::axil_r_t exp_q [$];
        banked_ram_pkg::axil_r_t got;
        banked_ram_pkg::axil_r_t exp_beat;
        int n;
        int issued;
        int done;
        int cycles;
        int idle_cnt;
        bit ar_busy;
        n        = plan_q.size();
        issued   = 0;
        done     = 0;
        cycles   = 0;
        idle_cnt = 0;
        ar_busy  = 1'b0;
        rready  <= (mode == 0);
        while (done < n) begin
            @(posedge rd_clk);
            cycles++;
            idle_cnt++;
            if (idle_cnt > TIMEOUT) begin
                stop_run("Timeout waiting for read traffic to make progress");
            end
            // R before AR since its beat belongs to an earlier AR
            if (rvalid && rready) begin
                if (exp_q.size() == 0) begin
                    stop_run("Read data returned with no read outstanding");
                end
                got = '{data: rdata, resp: rresp};
                check_rdata(got, exp_q.pop_front());
                done++;
                idle_cnt = 0;
            end
            if (arvalid && arready) begin
                exp_beat.data = model_mem[plan_q[issued]];
                exp_beat.resp = 2'b00;
                exp_q.push_back(exp_beat);
                issued++;
                arvalid <= 1'b0;
                ar_busy  = 1'b0;
                idle_cnt = 0;
            end
            if (exp_q.size() > banked_ram_pkg::R_FIFO_DEPTH) begin
                stop_run("More reads accepted than the response buffer can hold");
            end
            // Stalled R must have let exactly one buffer's worth through
            if (mode == 2 && cycles == STALL_CYCLES && n >= banked_ram_pkg::R_FIFO_DEPTH
                    && exp_q.size() != banked_ram_pkg::R_FIFO_DEPTH) begin
                stop_run("Read acceptance under R stall did not reach the buffer depth");
            end
            if (!ar_busy && issued < n && (mode != 1 || $urandom_range(3) != 0)) begin
                arvalid <= 1'b1;
                araddr  <= make_addr(plan_q[issued]);
                ar_busy  = 1'b1;
            end
            case (mode)
                0:       rready <= 1'b1;
                1:       rready <= 1'($urandom_range(1));
                default: rready <= (cycles >= STALL_CYCLES);
            endcase
        end
        rready <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int w;
        int idx;
        banked_ram_pkg::strb_t strb;
        void'($urandom(SEED));
        rd_clk  = 1'b0;
        rd_srst = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge rd_clk);
        rd_srst <= 1'b0;
        @(posedge rd_clk);

        // Idle outputs out of reset
        check_low(bvalid, "bvalid");
        check_low(rvalid, "rvalid");
        check_low(awready, "awready");
        check_low(wready, "wready");

        // Same word index in every bank then scattered writes
        w = $urandom_range((1 << banked_ram_pkg::BANK_ADDR_WID) - 1);
        for (int b = 0; b < banked_ram_pkg::NUM_BANKS; b++) begin
            do_write((b << banked_ram_pkg::BANK_ADDR_WID) | w,
                     banked_ram_pkg::word_t'($urandom), 4'hF);
        end
        repeat (12) do_write($urandom_range(NUM_WORDS - 1),
                             banked_ram_pkg::word_t'($urandom), 4'hF);

        // Read back everything written so far
        plan_q = written_q;
        run_reads(0);

        // Partial strobe must leave the old word
        idx  = written_q[$urandom_range(written_q.size() - 1)];
        strb = banked_ram_pkg::strb_t'($urandom_range(14));
        do_write(idx, banked_ram_pkg::word_t'($urandom), strb);
        plan_q.delete();
        plan_q.push_back(idx);
        run_reads(0);

        // Back-to-back reads then random R stalls then one long stall
        fill_random_reads(16);
        run_reads(0);
        fill_random_reads(16);
        run_reads(1);
        fill_random_reads(8);
        run_reads(2);

        // Long random mix
        for (int op = 0; op < MIX_OPS; op++) begin
            if ($urandom_range(2) == 0) begin
                fill_random_reads($urandom_range(6, 1));
                run_reads(1);
            end else begin
                strb = ($urandom_range(7) == 0) ? banked_ram_pkg::strb_t'($urandom_range(14))
                                                : 4'hF;
                do_write($urandom_range(NUM_WORDS - 1),
                         banked_ram_pkg::word_t'($urandom), strb);
            end
        end

        repeat (4) @(posedge rd_clk);
        $display("Test OK");
        $finish;
    end

endmodule : tb_banked_ram
